// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --assert --timescale 1ns/1ps -j 0
TOP       := addsub_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/addsub_assert.sv ====
// handshake checker: concurrent assertions on req/ack sequencing and result stability
`timescale 1ns/1ps

module addsub_assert (
  input logic                          i_clk,
  input logic                          i_arst_n,
  input logic                          i_req,
  input logic                          i_ack,
  input logic [addsub_pkg::DATA_W-1:0] i_sum,
  input logic                          i_carry,
  input logic                          i_ovf,
  input logic                          i_zero,
  input addsub_pkg::ctrl_state_e       i_state
);
  import addsub_pkg::*;

  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_ack |-> $past(i_req))
    else begin
      $error("ack high without a request on the cycle before");
      fail_count++;
    end

  ack_holds: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_ack && i_req) |=> i_ack)
    else begin
      $error("ack dropped while req was still high");
      fail_count++;
    end

  // rise lands 3 cycles after the idle sample, seen one edge later here
  ack_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(i_ack) |-> $past(i_state == ST_IDLE && i_req, 4))
    else begin
      $error("ack did not rise exactly 3 cycles after the request");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // result and reset
  //////////////////////////////////////////////////////////////////////

  result_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_ack |=> ($stable(i_sum) && $stable(i_carry) && $stable(i_ovf) && $stable(i_zero)))
    else begin
      $error("result changed while ack was high");
      fail_count++;
    end

  reset_idle: assert property (@(posedge i_clk)
    $rose(i_arst_n) |-> (i_state == ST_IDLE && !i_ack))
    else begin
      $error("controller not idle with ack low after reset");
      fail_count++;
    end

endmodule

// ==== bench/addsub_tb.sv ====
// add/subtract unit testbench driving four-phase requests against an arithmetic reference model
`timescale 1ns/1ps

module addsub_tb;
  import addsub_pkg::*;

  localparam int NUM_RANDOM = 200;
  // 22 directed and the random requests at 7 cycles each plus margin
  localparam int MAX_CYCLES = (NUM_RANDOM + 50) * 8;
  localparam int SPAN       = 1 << DATA_W;
  localparam int S_MAX      = SPAN / 2 - 1;
  localparam int S_MIN      = -(SPAN / 2);

  logic              i_clk;
  logic              i_arst_n;
  logic              i_req;
  logic [DATA_W-1:0] i_a;
  logic [DATA_W-1:0] i_b;
  op_e               i_op;
  logic              i_cin;
  logic              o_ack;
  logic [DATA_W-1:0] o_sum;
  logic              o_carry;
  logic              o_ovf;
  logic              o_zero;

  int     errors       = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     cycles       = 0;
  integer seed;

  // carry-chain cases that ripple across section boundaries
  logic [DATA_W-1:0] chain_a [3] = '{16'hFFFF, 16'h0FFF, 16'h00FF};
  logic [DATA_W-1:0] chain_b [3] = '{16'h0001, 16'h0001, 16'h0F01};

  addsub_top UUT (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (i_req),
    .i_a      (i_a),
    .i_b      (i_b),
    .i_op     (i_op),
    .i_cin    (i_cin),
    .o_ack    (o_ack),
    .o_sum    (o_sum),
    .o_carry  (o_carry),
    .o_ovf    (o_ovf),
    .o_zero   (o_zero)
  );

  bind addsub_top addsub_assert u_assert (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (i_req),
    .i_ack    (o_ack),
    .i_sum    (o_sum),
    .i_carry  (o_carry),
    .i_ovf    (o_ovf),
    .i_zero   (o_zero),
    .i_state  (u_ctrl.state)
  );

  always #20 i_clk = ~i_clk;

  // run limit
  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////////////////////////

  // plain integer arithmetic where carry reads as no-borrow for sub and sbb
  task automatic model_result(input op_e op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b, input logic cin,
                              output logic [DATA_W-1:0] exp_sum, output logic exp_carry,
                              output logic exp_ovf, output logic exp_zero);
    int carry_in;
    int wide;
    int sval;
    carry_in = ((op == OP_ADC || op == OP_SBB) && cin) ? 1 : 0;
    if (op == OP_ADD || op == OP_ADC) begin
      wide      = int'(a) + int'(b) + carry_in;
      sval      = int'($signed(a)) + int'($signed(b)) + carry_in;
      exp_carry = (wide >= SPAN);
    end else begin
      wide      = int'(a) - int'(b) - carry_in;
      sval      = int'($signed(a)) - int'($signed(b)) - carry_in;
      exp_carry = (wide >= 0);
    end
    exp_sum  = wide[DATA_W-1:0];
    exp_ovf  = (sval > S_MAX) || (sval < S_MIN);
    exp_zero = (exp_sum == '0);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %0t %s expected 0x%04h actual 0x%04h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic int total_fails();
    return errors + UUT.u_assert.fail_count;
  endfunction

  // one four-phase transaction with req held hold_cycles extra after ack
  task automatic run_request(input op_e op, input logic [DATA_W-1:0] a,
                             input logic [DATA_W-1:0] b, input logic cin,
                             input int hold_cycles);
    logic [DATA_W-1:0] exp_sum;
    logic              exp_carry;
    logic              exp_ovf;
    logic              exp_zero;
    @(posedge i_clk);
    i_a   <= a;
    i_b   <= b;
    i_op  <= op;
    i_cin <= cin;
    i_req <= 1'b1;
    @(negedge i_clk);
    while (!o_ack) @(negedge i_clk);
    model_result(op, a, b, cin, exp_sum, exp_carry, exp_ovf, exp_zero);
    check_word("o_sum", exp_sum, o_sum);
    check_flag("o_carry", exp_carry, o_carry);
    check_flag("o_ovf", exp_ovf, o_ovf);
    check_flag("o_zero", exp_zero, o_zero);
    repeat (hold_cycles) @(posedge i_clk);
    @(posedge i_clk);
    i_req <= 1'b0;
    @(negedge i_clk);
    while (o_ack) @(negedge i_clk);
  endtask

  task automatic close_test(input int num, input string name, input int fails_before);
    int new_fails;
    // one more edge so assertions started on the last edges are evaluated
    @(posedge i_clk);
    @(negedge i_clk);
    new_fails = total_fails() - fails_before;
    if (new_fails == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", num, name, new_fails);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                fails_before;
    integer            rnd;
    logic [DATA_W-1:0] ra;
    logic [DATA_W-1:0] rb;
    i_clk    = 1'b0;
    i_arst_n = 1'b0;
    i_req    = 1'b0;
    i_a      = '0;
    i_b      = '0;
    i_op     = OP_ADD;
    i_cin    = 1'b0;
    seed     = 21;

    fails_before = total_fails();
    repeat (10) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    check_flag("o_ack", 1'b0, o_ack);
    check_word("o_sum", '0, o_sum);
    close_test(1, "reset", fails_before);

    fails_before = total_fails();
    for (int i = 0; i < 3; i++) begin
      for (int c = 0; c < 2; c++) begin
        run_request(OP_ADD, chain_a[i], chain_b[i], c[0], 0);
        run_request(OP_ADC, chain_a[i], chain_b[i], c[0], 0);
      end
    end
    close_test(2, "carry chain", fails_before);

    fails_before = total_fails();
    run_request(OP_SUB, 16'h1234, 16'h1234, 1'b0, 0);
    run_request(OP_SUB, 16'h0000, 16'h0001, 1'b0, 0);
    run_request(OP_SBB, 16'h1234, 16'h1234, 1'b1, 0);
    run_request(OP_SBB, 16'h5000, 16'h1000, 1'b0, 0);
    run_request(OP_SBB, 16'h5000, 16'h1000, 1'b1, 0);
    close_test(3, "subtract", fails_before);

    fails_before = total_fails();
    run_request(OP_ADD, 16'h7FFF, 16'h0001, 1'b0, 0);
    run_request(OP_SUB, 16'h8000, 16'h0001, 1'b0, 0);
    run_request(OP_ADD, 16'h1000, 16'h2000, 1'b0, 0);
    run_request(OP_ADD, 16'hFF00, 16'hFF00, 1'b0, 0);
    close_test(4, "overflow", fails_before);

    fails_before = total_fails();
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = $random(seed);
      ra  = rnd[DATA_W-1:0];
      rnd = $random(seed);
      rb  = rnd[DATA_W-1:0];
      run_request(op_e'(rnd[17:16]), ra, rb, rnd[18], 0);
    end
    close_test(5, "random", fails_before);

    // the bound assertions watch ack and the result during the hold
    fails_before = total_fails();
    run_request(OP_ADC, 16'hA5A5, 16'h5A5A, 1'b1, 10);
    close_test(6, "back-pressure", fails_before);

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && total_fails() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/addsub_pkg.sv
rtl/operand_if.sv
rtl/addsub_ctrl.sv
rtl/operand_stage.sv
rtl/carry_select_adder.sv
rtl/result_stage.sv
rtl/addsub_top.sv
bench/addsub_assert.sv
bench/addsub_tb.sv

// ==== rtl/addsub_ctrl.sv ====
// addsub controller: four-phase req/ack sequencer issuing operand and result load strobes
`timescale 1ns/1ps

module addsub_ctrl (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_req,
  output logic o_ack,
  output logic o_load_ops,
  output logic o_load_res
);
  import addsub_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // idle -> load -> calc -> ack, then back to idle once req drops
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (i_req) begin
          state_nxt = ST_LOAD;
        end
      end
      ST_LOAD: begin
        state_nxt = ST_CALC;
      end
      ST_CALC: begin
        state_nxt = ST_ACK;
      end
      ST_ACK: begin
        if (!i_req) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // strobes are one cycle wide since each state lasts exactly one cycle
  assign o_load_ops = (state == ST_LOAD);
  assign o_load_res = (state == ST_CALC);

  // ack rises one edge after entering ack and falls with the sampled req
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= (state == ST_ACK) && i_req;
    end
  end

endmodule

// ==== rtl/addsub_pkg.sv ====
// addsub package: shared widths, opcode and control state encodings for the add/subtract unit
package addsub_pkg;

  //////////////////////////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////////////////////////

  // operand and sum width
  localparam int DATA_W = 16;

  // width of one carry-select section
  localparam int SECTION_W = 4;

  // number of uniform sections across the word
  localparam int NUM_SECTIONS = DATA_W / SECTION_W;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // opcode as seen on the request side
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_ADC = 2'b01,
    OP_SUB = 2'b10,
    OP_SBB = 2'b11
  } op_e;

  // handshake sequencer states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_LOAD = 2'b01,
    ST_CALC = 2'b10,
    ST_ACK  = 2'b11
  } ctrl_state_e;

endpackage

// ==== rtl/addsub_top.sv ====
// add/subtract unit top: handshake controller around operand stage, carry-select adder and result stage
`timescale 1ns/1ps

module addsub_top (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic                          i_req,
  input  logic [addsub_pkg::DATA_W-1:0] i_a,
  input  logic [addsub_pkg::DATA_W-1:0] i_b,
  input  addsub_pkg::op_e               i_op,
  input  logic                          i_cin,
  output logic                          o_ack,
  output logic [addsub_pkg::DATA_W-1:0] o_sum,
  output logic                          o_carry,
  output logic                          o_ovf,
  output logic                          o_zero
);
  import addsub_pkg::*;

  logic              load_ops;
  logic              load_res;
  logic [DATA_W-1:0] adder_sum;
  logic              adder_cout;

  operand_if ops_if ();

  addsub_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_req      (i_req),
    .o_ack      (o_ack),
    .o_load_ops (load_ops),
    .o_load_res (load_res)
  );

  operand_stage u_operand (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_load   (load_ops),
    .i_a      (i_a),
    .i_b      (i_b),
    .i_op     (i_op),
    .i_cin    (i_cin),
    .ops      (ops_if.src)
  );

  carry_select_adder u_adder (
    .ops    (ops_if.adder),
    .o_sum  (adder_sum),
    .o_cout (adder_cout)
  );

  result_stage u_result (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_load   (load_res),
    .i_sum    (adder_sum),
    .i_cout   (adder_cout),
    .ops      (ops_if.flags),
    .o_sum    (o_sum),
    .o_carry  (o_carry),
    .o_ovf    (o_ovf),
    .o_zero   (o_zero)
  );

endmodule

// ==== rtl/carry_select_adder.sv ====
// carry-select adder: uniform ripple sections computed for both carry-ins, picked by the incoming carry
`timescale 1ns/1ps

module carry_select_adder (
  operand_if.adder                      ops,
  output logic [addsub_pkg::DATA_W-1:0] o_sum,
  output logic                          o_cout
);
  import addsub_pkg::*;

  // carry into each section, last entry is the final carry-out
  logic [NUM_SECTIONS:0] sec_carry;

  assign sec_carry[0] = ops.cin;

  for (genvar s = 0; s < NUM_SECTIONS; s++) begin : g_sec
    localparam int LSB = s * SECTION_W;

    if (s == 0) begin : g_first
      // lowest section sees the real carry-in, nothing to select
      logic [SECTION_W:0] c;

      assign c[0] = sec_carry[0];
      for (genvar k = 0; k < SECTION_W; k++) begin : g_fa
        full_adder u_fa (
          .i_x (ops.a[LSB+k]),
          .i_y (ops.b_eff[LSB+k]),
          .i_c (c[k]),
          .o_s (o_sum[LSB+k]),
          .o_c (c[k+1])
        );
      end
      assign sec_carry[s+1] = c[SECTION_W];
    end else begin : g_sel
      logic [SECTION_W:0]   c0;
      logic [SECTION_W:0]   c1;
      logic [SECTION_W-1:0] s0;
      logic [SECTION_W-1:0] s1;

      // speculative chains for carry-in 0 and 1
      assign c0[0] = 1'b0;
      assign c1[0] = 1'b1;
      for (genvar k = 0; k < SECTION_W; k++) begin : g_fa
        full_adder u_fa0 (
          .i_x (ops.a[LSB+k]),
          .i_y (ops.b_eff[LSB+k]),
          .i_c (c0[k]),
          .o_s (s0[k]),
          .o_c (c0[k+1])
        );
        full_adder u_fa1 (
          .i_x (ops.a[LSB+k]),
          .i_y (ops.b_eff[LSB+k]),
          .i_c (c1[k]),
          .o_s (s1[k]),
          .o_c (c1[k+1])
        );
      end

      // 2-to-1 select on the carry from the section below
      assign o_sum[LSB +: SECTION_W] = sec_carry[s] ? s1 : s0;
      assign sec_carry[s+1]          = sec_carry[s] ? c1[SECTION_W] : c0[SECTION_W];
    end
  end

  assign o_cout = sec_carry[NUM_SECTIONS];

endmodule

// one-bit full adder, only used by the sections above
module full_adder (
  input  logic i_x,
  input  logic i_y,
  input  logic i_c,
  output logic o_s,
  output logic o_c
);

  logic half;

  assign half = i_x ^ i_y;
  assign o_s  = half ^ i_c;
  // generate or propagate
  assign o_c  = (i_x & i_y) | (half & i_c);

endmodule

// ==== rtl/operand_if.sv ====
// operand bundle: prepared operands and carry-in from the operand stage to the adder and flags
`timescale 1ns/1ps

interface operand_if;
  import addsub_pkg::*;

  // first operand, passed through unchanged
  logic [DATA_W-1:0] a;
  // second operand after the opcode's inversion
  logic [DATA_W-1:0] b_eff;
  // carry-in after the opcode's rule
  logic              cin;

  // operand stage drives the bundle
  modport src (
    output a, b_eff, cin
  );

  // adder consumes the full bundle
  modport adder (
    input a, b_eff, cin
  );

  // result stage only looks at the sign bits
  modport flags (
    input a, b_eff
  );

endinterface

// ==== rtl/operand_stage.sv ====
// operand stage: captures the request operands and applies the opcode's inversion and carry rule
`timescale 1ns/1ps

module operand_stage (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_load,
  input  logic [addsub_pkg::DATA_W-1:0] i_a,
  input  logic [addsub_pkg::DATA_W-1:0] i_b,
  input  addsub_pkg::op_e              i_op,
  input  logic                         i_cin,
  operand_if.src                       ops
);
  import addsub_pkg::*;

  logic [DATA_W-1:0] b_eff_d;
  logic              cin_d;

  // subtraction is a plus inverted b plus carry
  assign b_eff_d = (i_op == OP_SUB || i_op == OP_SBB) ? ~i_b : i_b;

  // i_cin is the borrow-in for sbb, so it goes in inverted
  always_comb begin
    case (i_op)
      OP_ADD:  cin_d = 1'b0;
      OP_ADC:  cin_d = i_cin;
      OP_SUB:  cin_d = 1'b1;
      OP_SBB:  cin_d = ~i_cin;
      default: cin_d = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ops.a     <= '0;
      ops.b_eff <= '0;
      ops.cin   <= 1'b0;
    end else if (i_load) begin
      ops.a     <= i_a;
      ops.b_eff <= b_eff_d;
      ops.cin   <= cin_d;
    end
  end

endmodule

// ==== rtl/result_stage.sv ====
// result stage: holds sum and carry-out and produces overflow and zero flags
`timescale 1ns/1ps

module result_stage (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic                          i_load,
  input  logic [addsub_pkg::DATA_W-1:0] i_sum,
  input  logic                          i_cout,
  operand_if.flags                      ops,
  output logic [addsub_pkg::DATA_W-1:0] o_sum,
  output logic                          o_carry,
  output logic                          o_ovf,
  output logic                          o_zero
);
  import addsub_pkg::*;

  logic ovf_d;

  // signed overflow: like-signed operands, result sign flipped
  assign ovf_d = (ops.a[DATA_W-1] == ops.b_eff[DATA_W-1]) &&
                 (i_sum[DATA_W-1] != ops.a[DATA_W-1]);

  //////////////////////////////////////////////////////////////////////
  // result registers
  //////////////////////////////////////////////////////////////////////

  // for sub and sbb the carry reads as no-borrow
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_sum   <= '0;
      o_carry <= 1'b0;
      o_ovf   <= 1'b0;
    end else if (i_load) begin
      o_sum   <= i_sum;
      o_carry <= i_cout;
      o_ovf   <= ovf_d;
    end
  end

  // zero follows the held sum directly
  assign o_zero = (o_sum == '0);

endmodule
